// ==== FpgaVirtualConsole.f ====
hw/ConsolePkg.sv
hw/UartReceiver.sv
hw/Vt100Parser.sv
hw/TextRam.sv
hw/DisplayScanner.sv
hw/FpgaVirtualConsole.sv
verif/ClockGen.sv
verif/ConsoleTb.sv

// ==== hw/ConsolePkg.sv ====
package ConsolePkg;

    // Field widths
    localparam int CharWidth = 8;
    localparam int RowWidth = 5;
    localparam int ColWidth = 7;
    localparam int AddrWidth = 12;

    typedef logic [CharWidth-1:0] CharCode_t;
    typedef logic [RowWidth-1:0] RowIndex_t;
    typedef logic [ColWidth-1:0] ColIndex_t;

    // row * Cols + col
    typedef logic [AddrWidth-1:0] TextAddr_t;

    typedef struct packed {
        RowIndex_t row;
        ColIndex_t col;
    } Cursor_t;

    typedef struct packed {
        TextAddr_t address;
        CharCode_t data;
        logic      wren;
    } TextRamWrite_t;

    typedef struct packed {
        logic      hsync;
        logic      vsync;
        logic      active;
        CharCode_t character;
        logic      cursor;
    } VideoSignal_t;

    // Byte codes seen by the VT100 parser
    localparam CharCode_t AsciiBs = 8'h08;
    localparam CharCode_t AsciiLf = 8'h0A;
    localparam CharCode_t AsciiCr = 8'h0D;
    localparam CharCode_t AsciiEsc = 8'h1B;
    localparam CharCode_t AsciiSpace = 8'h20;
    localparam CharCode_t AsciiZero = 8'h30;
    localparam CharCode_t AsciiNine = 8'h39;
    localparam CharCode_t AsciiSemicolon = 8'h3B;
    localparam CharCode_t AsciiCapH = 8'h48;
    localparam CharCode_t AsciiCapJ = 8'h4A;
    localparam CharCode_t AsciiLeftBracket = 8'h5B;
    localparam CharCode_t AsciiTilde = 8'h7E;

endpackage

// ==== hw/DisplayScanner.sv ====
`timescale 1ns/1ns
module DisplayScanner #(
    parameter int Cols = 16,
    parameter int Rows = 8,
    parameter int HBlank = 4,
    parameter int VBlank = 2,
    parameter int BlinkFrames = 2
) (
    input  logic                     clk,
    input  logic                     arstN,
    input  ConsolePkg::Cursor_t      cursor,
    output ConsolePkg::TextAddr_t    readAddr,
    input  ConsolePkg::CharCode_t    readData,
    output ConsolePkg::VideoSignal_t vga
);
    import ConsolePkg::*;

    localparam int LineCycles = Cols + HBlank;
    localparam int FrameLines = Rows + VBlank;
    localparam int HWidth = $clog2(LineCycles);
    localparam int VWidth = $clog2(FrameLines);
    localparam int FrameWidth = $clog2(BlinkFrames + 1);

    typedef struct packed {
        logic hsync;
        logic vsync;
        logic active;
        logic cursor;
    } CellFlags_t;

    logic [HWidth-1:0] colCount;
    logic [VWidth-1:0] lineCount;
    logic [FrameWidth-1:0] frameCount;
    logic blinkOn;
    logic frameEnd;
    CellFlags_t cellNow;
    CellFlags_t cellDelayed;

    // Vsync rising edge at counter position
    assign frameEnd = (colCount == '0) && (lineCount == VWidth'(Rows));

    always_comb begin
        cellNow.active = (colCount < HWidth'(Cols)) && (lineCount < VWidth'(Rows));
        cellNow.hsync = (colCount == HWidth'(Cols));
        cellNow.vsync = (lineCount == VWidth'(Rows));
        cellNow.cursor = cellNow.active && blinkOn
            && (RowIndex_t'(lineCount) == cursor.row)
            && (ColIndex_t'(colCount) == cursor.col);
        readAddr = cellNow.active
            ? TextAddr_t'(lineCount) * TextAddr_t'(Cols) + TextAddr_t'(colCount)
            : '0;
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            colCount <= '0;
            lineCount <= '0;
        end else if (colCount == HWidth'(LineCycles - 1)) begin
            colCount <= '0;
            lineCount <= (lineCount == VWidth'(FrameLines - 1)) ? '0 : lineCount + 1'b1;
        end else begin
            colCount <= colCount + 1'b1;
        end
    end

    // Blink phase, starts on
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            frameCount <= '0;
            blinkOn <= 1'b1;
        end else if (frameEnd) begin
            if (frameCount == FrameWidth'(BlinkFrames - 1)) begin
                frameCount <= '0;
                blinkOn <= !blinkOn;
            end else begin
                frameCount <= frameCount + 1'b1;
            end
        end
    end

    // Flags wait one cycle for the RAM, then everything registers into vga
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            cellDelayed <= '0;
            vga <= '0;
        end else begin
            cellDelayed <= cellNow;
            vga.hsync <= cellDelayed.hsync;
            vga.vsync <= cellDelayed.vsync;
            vga.active <= cellDelayed.active;
            vga.character <= cellDelayed.active ? readData : '0;
            vga.cursor <= cellDelayed.cursor;
        end
    end

endmodule

// ==== hw/FpgaVirtualConsole.sv ====
`timescale 1ns/1ns
module FpgaVirtualConsole #(
    parameter int Cols = 16,
    parameter int Rows = 8,
    parameter int ClkFrequency = 10_000_000,
    parameter int Baud = 1_000_000,
    parameter int HBlank = 4,
    parameter int VBlank = 2,
    parameter int BlinkFrames = 2
) (
    input  logic                     clk,
    input  logic                     arstN,
    input  logic                     uartRx,
    output ConsolePkg::VideoSignal_t vga
);
    import ConsolePkg::*;

    logic uartReady;
    CharCode_t uartData;
    TextRamWrite_t ramWrite;
    Cursor_t cursor;
    TextAddr_t scanAddr;
    CharCode_t scanData;

    UartReceiver #(
        .ClkFrequency(ClkFrequency),
        .Baud(Baud)
    ) uartReceiver_i (
        .clk(clk),
        .arstN(arstN),
        .rx(uartRx),
        .dataReady(uartReady),
        .data(uartData)
    );

    Vt100Parser #(
        .Cols(Cols),
        .Rows(Rows)
    ) vt100Parser_i (
        .clk(clk),
        .arstN(arstN),
        .dataReady(uartReady),
        .data(uartData),
        .ramWrite(ramWrite),
        .cursor(cursor)
    );

    TextRam #(
        .Cols(Cols),
        .Rows(Rows)
    ) textRam_i (
        .clk(clk),
        .ramWrite(ramWrite),
        .readAddr(scanAddr),
        .readData(scanData)
    );

    DisplayScanner #(
        .Cols(Cols),
        .Rows(Rows),
        .HBlank(HBlank),
        .VBlank(VBlank),
        .BlinkFrames(BlinkFrames)
    ) displayScanner_i (
        .clk(clk),
        .arstN(arstN),
        .cursor(cursor),
        .readAddr(scanAddr),
        .readData(scanData),
        .vga(vga)
    );

endmodule

// ==== hw/TextRam.sv ====
`timescale 1ns/1ns
module TextRam #(
    parameter int Cols = 16,
    parameter int Rows = 8
) (
    input  logic                      clk,
    input  ConsolePkg::TextRamWrite_t ramWrite,
    input  ConsolePkg::TextAddr_t     readAddr,
    output ConsolePkg::CharCode_t     readData
);
    import ConsolePkg::*;

    localparam int Cells = Cols * Rows;
    localparam int IndexWidth = $clog2(Cells);

    CharCode_t memory [Cells];
    logic [IndexWidth-1:0] writeIndex;
    logic [IndexWidth-1:0] readIndex;

    // Both users keep their addresses below Cells
    assign writeIndex = ramWrite.address[IndexWidth-1:0];
    assign readIndex = readAddr[IndexWidth-1:0];

    always_ff @(posedge clk) begin
        if (ramWrite.wren) begin
            memory[writeIndex] <= ramWrite.data;
        end
    end

    // Read before write on a collision
    always_ff @(posedge clk) begin
        readData <= memory[readIndex];
    end

endmodule

// ==== hw/UartReceiver.sv ====
`timescale 1ns/1ns
module UartReceiver #(
    parameter int ClkFrequency = 10_000_000,
    parameter int Baud = 1_000_000
) (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  rx,
    output logic                  dataReady,
    output ConsolePkg::CharCode_t data
);
    import ConsolePkg::*;

    localparam int BitCycles = ClkFrequency / Baud;
    localparam int HalfBit = BitCycles / 2;
    localparam int CountWidth = $clog2(BitCycles + 1);
    // Bit 0 is the start bit, 1 to 8 are data
    localparam int StopBit = 9;

    logic [1:0] rxSync;
    logic busy;
    logic [3:0] bitIndex;
    logic [CountWidth-1:0] cycleCount;
    CharCode_t shiftReg;
    logic sampleNow;

    assign sampleNow = busy && (cycleCount == '0);
    assign dataReady = sampleNow && (bitIndex == 4'(StopBit)) && rxSync[1];
    assign data = shiftReg;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rxSync <= 2'b11;
            busy <= 1'b0;
            bitIndex <= '0;
            cycleCount <= '0;
        end else begin
            rxSync <= {rxSync[0], rx};
            if (!busy) begin
                // Falling edge of the start bit
                if (!rxSync[1]) begin
                    busy <= 1'b1;
                    bitIndex <= '0;
                    cycleCount <= CountWidth'(HalfBit - 1);
                end
            end else if (sampleNow) begin
                cycleCount <= CountWidth'(BitCycles - 1);
                bitIndex <= bitIndex + 1'b1;
                // Start bit gone high again at mid-bit, treat as a glitch
                if (bitIndex == '0 && rxSync[1]) begin
                    busy <= 1'b0;
                end
                if (bitIndex == 4'(StopBit)) begin
                    busy <= 1'b0;
                end
            end else begin
                cycleCount <= cycleCount - 1'b1;
            end
        end
    end

    // LSB first
    always_ff @(posedge clk) begin
        if (sampleNow && bitIndex != '0 && bitIndex != 4'(StopBit)) begin
            shiftReg <= {rxSync[1], shiftReg[7:1]};
        end
    end

endmodule

// ==== hw/Vt100Parser.sv ====
`timescale 1ns/1ns
module Vt100Parser #(
    parameter int Cols = 16,
    parameter int Rows = 8
) (
    input  logic                      clk,
    input  logic                      arstN,
    input  logic                      dataReady,
    input  ConsolePkg::CharCode_t     data,
    output ConsolePkg::TextRamWrite_t ramWrite,
    output ConsolePkg::Cursor_t       cursor
);
    import ConsolePkg::*;

    localparam int Cells = Cols * Rows;

    typedef enum logic [1:0] {
        Ground,
        Escape,
        Csi,
        Clear
    } ParserState_t;

    // Saturating CSI parameter
    typedef logic [7:0] CsiParam_t;

    ParserState_t state;
    CsiParam_t param1;
    CsiParam_t param2;
    logic paramIndex;
    TextAddr_t clearAddr;

    TextAddr_t cursorAddr;
    RowIndex_t nextRow;
    logic isPrintable;
    logic isDigit;

    function automatic CsiParam_t addDigit(input CsiParam_t value, input CharCode_t digit);
        logic [11:0] sum;
        sum = 12'(value) * 12'd10 + 12'(digit - AsciiZero);
        return (sum > 12'd255) ? 8'd255 : sum[7:0];
    endfunction

    // Parameters are 1-based, zero means default
    function automatic RowIndex_t toRow(input CsiParam_t p);
        if (p == 8'd0) begin
            return '0;
        end
        if (int'(p) > Rows) begin
            return RowIndex_t'(Rows - 1);
        end
        return RowIndex_t'(p - 8'd1);
    endfunction

    function automatic ColIndex_t toCol(input CsiParam_t p);
        if (p == 8'd0) begin
            return '0;
        end
        if (int'(p) > Cols) begin
            return ColIndex_t'(Cols - 1);
        end
        return ColIndex_t'(p - 8'd1);
    endfunction

    always_comb begin
        cursorAddr = TextAddr_t'(cursor.row) * TextAddr_t'(Cols) + TextAddr_t'(cursor.col);
        nextRow = (cursor.row == RowIndex_t'(Rows - 1)) ? '0 : cursor.row + 1'b1;
        isPrintable = (data >= AsciiSpace) && (data <= AsciiTilde);
        isDigit = (data >= AsciiZero) && (data <= AsciiNine);
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= Clear;
            clearAddr <= '0;
            cursor <= '0;
            ramWrite <= '0;
            param1 <= '0;
            param2 <= '0;
            paramIndex <= 1'b0;
        end else begin
            ramWrite.wren <= 1'b0;
            case (state)
                Clear: begin
                    // One space per cycle, incoming bytes are lost meanwhile
                    ramWrite <= '{address: clearAddr, data: AsciiSpace, wren: 1'b1};
                    clearAddr <= clearAddr + 1'b1;
                    if (clearAddr == TextAddr_t'(Cells - 1)) begin
                        state <= Ground;
                    end
                end
                Ground: begin
                    if (dataReady && isPrintable) begin
                        ramWrite <= '{address: cursorAddr, data: data, wren: 1'b1};
                        if (cursor.col == ColIndex_t'(Cols - 1)) begin
                            cursor.col <= '0;
                            cursor.row <= nextRow;
                        end else begin
                            cursor.col <= cursor.col + 1'b1;
                        end
                    end else if (dataReady) begin
                        case (data)
                            AsciiCr: cursor.col <= '0;
                            AsciiLf: cursor.row <= nextRow;
                            AsciiBs: begin
                                if (cursor.col != '0) begin
                                    cursor.col <= cursor.col - 1'b1;
                                end
                            end
                            AsciiEsc: state <= Escape;
                            default: ;
                        endcase
                    end
                end
                Escape: begin
                    if (dataReady) begin
                        param1 <= '0;
                        param2 <= '0;
                        paramIndex <= 1'b0;
                        state <= (data == AsciiLeftBracket) ? Csi : Ground;
                    end
                end
                Csi: begin
                    if (dataReady && isDigit) begin
                        if (paramIndex) begin
                            param2 <= addDigit(param2, data);
                        end else begin
                            param1 <= addDigit(param1, data);
                        end
                    end else if (dataReady && data == AsciiSemicolon) begin
                        paramIndex <= 1'b1;
                    end else if (dataReady) begin
                        // Final byte
                        state <= Ground;
                        if (data == AsciiCapH) begin
                            cursor.row <= toRow(param1);
                            cursor.col <= toCol(param2);
                        end else if (data == AsciiCapJ && param1 == 8'd2) begin
                            state <= Clear;
                            clearAddr <= '0;
                        end
                    end
                end
            endcase
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns --top-module ConsoleTb \
    -f FpgaVirtualConsole.f -o VConsoleTb

result=$(./obj_dir/VConsoleTb) || true
printf '%s\n' "$result"

if printf '%s\n' "$result" | grep -qx "TEST PASS"; then
    exit 0
else
    echo "Simulation did not pass"
    exit 1
fi

// ==== verif/ClockGen.sv ====
`timescale 1ns/1ns
module ClockGen #(
    parameter int PeriodNs = 100,
    parameter int ResetCycles = 4
) (
    output logic clk,
    output logic arstN
);

    initial begin
        clk = 1'b0;
        forever #(PeriodNs / 2) clk = ~clk;
    end

    // Release lands just after a rising edge, like the other stimulus
    initial begin
        arstN = 1'b0;
        repeat (ResetCycles) @(posedge clk);
        #10;
        arstN = 1'b1;
    end

endmodule

// ==== verif/ConsoleTb.sv ====
`timescale 1ns/1ns
module ConsoleTb;
    import ConsolePkg::*;

    localparam int Cols = 16;
    localparam int Rows = 8;
    localparam int Cells = Cols * Rows;
    localparam int BitClocks = 10;
    localparam int HBlank = 4;
    localparam int VBlank = 2;
    localparam int BlinkFrames = 2;
    localparam int LineCycles = Cols + HBlank;
    localparam int FrameCycles = (Cols + HBlank) * (Rows + VBlank);
    localparam int Seed = 32'h16a2;

    // Test length, used for the timeout
    localparam int StringRounds = 6;
    localparam int MixRounds = 6;
    localparam int MoveRounds = 8;
    localparam int MaxStringBytes = 40;
    localparam int MoveBytes = 10;
    localparam int BitsPerByte = 13;
    localparam int BlinkCheckFrames = 2 * BlinkFrames + 1;
    localparam int CheckedFrames = 3 + StringRounds + MixRounds + MoveRounds + BlinkCheckFrames;
    localparam int StimulusBytes = (StringRounds + MixRounds + 1) * MaxStringBytes
        + MoveRounds * MoveBytes + 4;
    localparam int TimeoutCycles = 4 * (StimulusBytes * BitsPerByte * BitClocks
        + CheckedFrames * FrameCycles);

    typedef enum {ModeGround, ModeEscape, ModeCsi} ModelMode_t;

    logic clk;
    logic arstN;
    logic uartRx;
    VideoSignal_t vga;

    logic [7:0] screenModel [Cells];
    int modelRow;
    int modelCol;
    ModelMode_t modelMode;
    int param1;
    int param2;
    bit secondParam;

    int cycleCount = 0;
    int vsyncCount = 0;
    logic prevVsync = 1'b0;

    ClockGen #(.PeriodNs(100), .ResetCycles(4)) clockGen_i (.clk(clk), .arstN(arstN));

    FpgaVirtualConsole dut_i (
        .clk(clk),
        .arstN(arstN),
        .uartRx(uartRx),
        .vga(vga)
    );

    // Frame index for the blink phase is the number of vsync pulses seen so far
    always @(posedge clk) begin
        prevVsync <= vga.vsync;
        if (vga.vsync && !prevVsync) begin
            vsyncCount <= vsyncCount + 1;
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            $display("Timeout: the test did not finish within %0d cycles", TimeoutCycles);
            $display("TEST FAIL");
            $fatal(1, "Simulation stopped by the cycle limit");
        end
    end

    task automatic checkValue(input string name, input int got, input int expected);
        if (got !== expected) begin
            $display("Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, expected);
            $display("TEST FAIL");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic clearModel();
        int i;
        for (i = 0; i < Cells; i++) begin
            screenModel[i] = 8'h20;
        end
    endtask

    function automatic int clampParam(input int value, input int size);
        if (value == 0) begin
            return 0;
        end
        return (value > size) ? size - 1 : value - 1;
    endfunction

    // Screen and cursor model of the VT100 subset
    task automatic modelByte(input int value);
        case (modelMode)
            ModeGround: begin
                if (value >= 'h20 && value <= 'h7e) begin
                    screenModel[modelRow * Cols + modelCol] = 8'(value);
                    modelCol++;
                    if (modelCol == Cols) begin
                        modelCol = 0;
                        modelRow = (modelRow + 1) % Rows;
                    end
                end else if (value == 'h0d) begin
                    modelCol = 0;
                end else if (value == 'h0a) begin
                    modelRow = (modelRow + 1) % Rows;
                end else if (value == 'h08 && modelCol > 0) begin
                    modelCol--;
                end else if (value == 'h1b) begin
                    modelMode = ModeEscape;
                end
            end
            ModeEscape: begin
                param1 = 0;
                param2 = 0;
                secondParam = 1'b0;
                modelMode = (value == 'h5b) ? ModeCsi : ModeGround;
            end
            default: begin
                if (value >= 'h30 && value <= 'h39) begin
                    if (secondParam) param2 = param2 * 10 + value - 'h30;
                    else param1 = param1 * 10 + value - 'h30;
                end else if (value == 'h3b) begin
                    secondParam = 1'b1;
                end else begin
                    modelMode = ModeGround;
                    if (value == 'h48) begin
                        modelRow = clampParam(param1, Rows);
                        modelCol = clampParam(param2, Cols);
                    end else if (value == 'h4a && param1 == 2) begin
                        clearModel();
                    end
                end
            end
        endcase
    endtask

    // 8N1, LSB first, then 1 to 3 idle bits
    task automatic uartSend(input int value);
        logic [9:0] bits;
        int idle;
        int i;
        bits = {1'b1, 8'(value), 1'b0};
        idle = $urandom_range(1, 3);
        for (i = 0; i < 10 + idle; i++) begin
            @(posedge clk);
            #10;
            uartRx = (i < 10) ? bits[i] : 1'b1;
            repeat (BitClocks - 1) @(posedge clk);
        end
    endtask

    task automatic sendByte(input int value);
        modelByte(value);
        uartSend(value);
    endtask

    task automatic sendRandomText(input bit withControls);
        int count;
        int i;
        int pick;
        count = $urandom_range(1, MaxStringBytes);
        for (i = 0; i < count; i++) begin
            pick = withControls ? $urandom_range(0, 5) : 5;
            case (pick)
                0: sendByte('h0d);
                1: sendByte('h0a);
                2: sendByte('h08);
                default: sendByte($urandom_range('h20, 'h7e));
            endcase
        end
    endtask

    // Missing, zero, in range or past the screen edge
    task automatic sendParam(input int limit);
        int kind;
        int value;
        kind = $urandom_range(0, 3);
        if (kind != 0) begin
            value = (kind == 1) ? 0 : (kind == 2) ? $urandom_range(1, limit)
                : $urandom_range(limit + 1, 99);
            if (value >= 10) sendByte('h30 + value / 10);
            sendByte('h30 + value % 10);
        end
    endtask

    task automatic sendCursorMove();
        sendByte('h1b);
        sendByte('h5b);
        sendParam(Rows);
        if ($urandom_range(0, 4) != 0) begin
            sendByte('h3b);
            sendParam(Cols);
        end
        sendByte('h48);
        sendByte($urandom_range('h21, 'h7e));
    endtask

    task automatic sendClear();
        sendByte('h1b);
        sendByte('h5b);
        sendByte('h32);
        sendByte('h4a);
        repeat (Cells + 20) @(posedge clk);
    endtask

    // Captures whole frames after a vsync falling edge and compares them with the model
    task automatic checkScreen(input int frames);
        logic [7:0] shownChar [Cells];
        logic shownCursor [Cells];
        int f;
        int idx;
        int pos;
        int frameIndex;
        int cursorIdx;
        bit phaseOn;
        for (f = 0; f < frames; f++) begin
            @(negedge clk);
            while (!vga.vsync) @(negedge clk);
            while (vga.vsync) @(negedge clk);
            frameIndex = vsyncCount;
            idx = 0;
            pos = -1;
            while (idx < Cells) begin
                if (pos < 0 && vga.active) begin
                    pos = 0;
                end
                // Raster shape from the first visible cell on
                if (pos >= 0) begin
                    checkValue("vga.active", int'(vga.active),
                        int'(pos % LineCycles < Cols));
                    checkValue("vga.hsync", int'(vga.hsync),
                        int'(pos % LineCycles == Cols));
                    checkValue("vga.vsync", int'(vga.vsync), 0);
                    pos++;
                end
                if (vga.active) begin
                    shownChar[idx] = vga.character;
                    shownCursor[idx] = vga.cursor;
                    idx++;
                end
                if (idx < Cells) @(negedge clk);
            end
            cursorIdx = modelRow * Cols + modelCol;
            phaseOn = ((frameIndex / BlinkFrames) % 2) == 0;
            for (idx = 0; idx < Cells; idx++) begin
                checkValue($sformatf("vga.character (frame %0d row %0d col %0d)",
                    frameIndex, idx / Cols, idx % Cols),
                    int'(shownChar[idx]), int'(screenModel[idx]));
                checkValue($sformatf("vga.cursor (frame %0d row %0d col %0d)",
                    frameIndex, idx / Cols, idx % Cols),
                    int'(shownCursor[idx]), (idx == cursorIdx && phaseOn) ? 1 : 0);
            end
        end
    endtask

    initial begin
        uartRx = 1'b1;
        void'($urandom(Seed));
        clearModel();
        modelRow = 0;
        modelCol = 0;
        modelMode = ModeGround;
        @(posedge arstN);
        repeat (Cells + 20) @(posedge clk);
        checkScreen(2);

        repeat (StringRounds) begin
            sendRandomText(1'b0);
            checkScreen(1);
        end
        repeat (MixRounds) begin
            sendRandomText(1'b1);
            checkScreen(1);
        end
        repeat (MoveRounds) begin
            sendCursorMove();
            checkScreen(1);
        end
        sendClear();
        checkScreen(1);

        // Blink over several consecutive frames
        sendRandomText(1'b1);
        checkScreen(BlinkCheckFrames);

        $display("TEST PASS");
        $finish;
    end

endmodule
